// ==== build.f ====
src/pcie_datalink_pkg.sv
src/replay_mem_pkg.sv
src/tlp_capture.sv
src/replay_buffer.sv
src/retry_management.sv
src/dll_tx_top.sv
sim/dll_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module dll_tx_tb -o dll_tx_sim > build.log 2>&1 &&
  ./obj_dir/dll_tx_sim > sim.log 2>&1 ||
  { cat build.log; echo "build or run error"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

// ==== sim/dll_tx_tb.sv ====
`timescale 1ns/1ps

module dll_tx_tb;
  import pcie_datalink_pkg::*;

  localparam int RETRY_SLOTS    = 4;
  localparam int REPLAY_TIMEOUT = 40;
  localparam int MAX_REPLAYS    = 3;
  localparam int MAX_CYCLES     = 6000;

  logic         clk_i = 1'b0;
  logic         rst_i;
  tlp_beat_t    tx_beat_i;
  logic         tx_beat_vld_i;
  ack_dllp_t    ack_i;
  logic         ack_vld_i;
  logic         replay_rdy_i = 1'b1;
  logic         tlp_sent_o;
  seq_num_t     tlp_seq_o;
  logic         retry_available_o;
  logic         retry_err_o;
  replay_beat_t replay_beat_o;
  logic         replay_vld_o;

  // scoreboard, indexed by the low six bits of the sequence number
  logic [31:0]  tlp_data [64][16];
  int           tlp_len [64];
  int           replay_cnt [64];
  int           next_seq;
  string        test_name = "reset";
  logic         err_test;
  logic         rdy_random;
  int unsigned  stim_state = 35861;
  int unsigned  rdy_state = 35861;
  int           mism_cnt = 0;
  int           fail_cnt = 0;
  int           cycle_cnt = 0;

  seq_num_t     exp_seq;
  logic [63:0]  outstanding;
  logic [63:0]  acked;
  int           out_cnt;
  logic [1:0]   ack_pipe;
  int           rp_idx;
  seq_num_t     rp_seq;
  logic         hold_q;
  replay_beat_t beat_q;
  logic         err_q;
  logic         nak_wait;
  int           nak_cnt;
  seq_num_t     nak_seq;
  logic [5:0]   rs;
  logic         ack_hit;
  logic         nak_hit;

  dll_tx_top #(
    .REPLAY_TIMEOUT(REPLAY_TIMEOUT)
  ) dll_tx_top_inst (
    .clk_i(clk_i), .rst_i(rst_i),
    .tx_beat_i(tx_beat_i), .tx_beat_vld_i(tx_beat_vld_i),
    .ack_i(ack_i), .ack_vld_i(ack_vld_i), .replay_rdy_i(replay_rdy_i),
    .tlp_sent_o(tlp_sent_o), .tlp_seq_o(tlp_seq_o),
    .retry_available_o(retry_available_o), .retry_err_o(retry_err_o),
    .replay_beat_o(replay_beat_o), .replay_vld_o(replay_vld_o)
  );

  always #10 clk_i = ~clk_i;

  assign rs      = replay_beat_o.seq[5:0];
  assign ack_hit = ack_vld_i && ack_i.is_ack && outstanding[ack_i.seq[5:0]];
  assign nak_hit = ack_vld_i && !ack_i.is_ack && outstanding[ack_i.seq[5:0]];

  function automatic int unsigned lcg_next(input int unsigned state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    stim_state = lcg_next(stim_state);
    return lo + int'((stim_state >> 16) % (hi - lo + 1));
  endfunction

  // ready low about a quarter of the time when enabled
  always @(negedge clk_i) begin
    rdy_state    = lcg_next(rdy_state);
    replay_rdy_i = !rdy_random || (rdy_state[31:30] != 2'd0);
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // reference model of the link side, updated from sampled outputs
  always @(posedge clk_i) begin
    if (rst_i) begin
      exp_seq     <= '0;
      outstanding <= '0;
      acked       <= '0;
      out_cnt     <= 0;
      ack_pipe    <= '0;
      rp_idx      <= 0;
      hold_q      <= 1'b0;
      err_q       <= 1'b0;
      nak_wait    <= 1'b0;
      for (int i = 0; i < 64; i++) begin
        replay_cnt[i] <= 0;
      end
    end else begin
      ack_pipe <= {ack_pipe[0], ack_hit};
      hold_q   <= replay_vld_o && !replay_rdy_i;
      beat_q   <= replay_beat_o;
      err_q    <= retry_err_o;
      out_cnt  <= out_cnt + int'(tlp_sent_o) - int'(ack_hit);
      if (tlp_sent_o) begin
        exp_seq                     <= exp_seq + seq_num_t'(1);
        outstanding[tlp_seq_o[5:0]] <= 1'b1;
      end
      if (ack_hit) begin
        outstanding[ack_i.seq[5:0]] <= 1'b0;
        acked[ack_i.seq[5:0]]       <= 1'b1;
      end
      if (replay_vld_o && replay_rdy_i) begin
        if (rp_idx == 0) begin
          rp_seq         <= replay_beat_o.seq;
          replay_cnt[rs] <= replay_cnt[rs] + 1;
        end
        rp_idx <= replay_beat_o.last ? 0 : rp_idx + 1;
      end
      if (nak_hit) begin
        nak_wait <= 1'b1;
        nak_cnt  <= 0;
        nak_seq  <= ack_i.seq;
      end else if (nak_wait) begin
        if (replay_vld_o && replay_beat_o.seq == nak_seq) begin
          nak_wait <= 1'b0;
        end else begin
          nak_cnt <= nak_cnt + 1;
        end
      end
    end
  end

  a_numbering: assert property (@(posedge clk_i) disable iff (rst_i)
    tlp_sent_o |-> tlp_seq_o == exp_seq)
  else begin
    mism_cnt++;
    $display("Mismatch %s: seq expected %h, actual %h", test_name,
             $sampled(exp_seq), $sampled(tlp_seq_o));
  end

  a_replay_data: assert property (@(posedge clk_i) disable iff (rst_i)
    replay_vld_o |-> replay_beat_o.data == tlp_data[rs][rp_idx[3:0]])
  else begin
    mism_cnt++;
    $display("Mismatch %s: data expected %h, actual %h", test_name,
             $sampled(tlp_data[rs][rp_idx[3:0]]), $sampled(replay_beat_o.data));
  end

  a_replay_last: assert property (@(posedge clk_i) disable iff (rst_i)
    replay_vld_o |-> replay_beat_o.last == (rp_idx == tlp_len[rs] - 1))
  else begin
    mism_cnt++;
    $display("Mismatch %s: last expected %b, actual %b", test_name,
             $sampled(rp_idx == tlp_len[rs] - 1), $sampled(replay_beat_o.last));
  end

  // first beat must name a TLP that was sent and not yet ACKed
  a_replay_first: assert property (@(posedge clk_i) disable iff (rst_i)
    replay_vld_o && rp_idx == 0 |-> outstanding[rs])
  else begin
    mism_cnt++;
    $display("Mismatch %s: first beat seq %h outstanding expected 1, actual 0",
             test_name, $sampled(replay_beat_o.seq));
  end

  a_replay_seq: assert property (@(posedge clk_i) disable iff (rst_i)
    replay_vld_o && rp_idx != 0 |-> replay_beat_o.seq == rp_seq)
  else begin
    mism_cnt++;
    $display("Mismatch %s: beat seq expected %h, actual %h", test_name,
             $sampled(rp_seq), $sampled(replay_beat_o.seq));
  end

  // beat and valid frozen while the sink stalls
  a_replay_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    hold_q |-> replay_vld_o && replay_beat_o == beat_q)
  else begin
    mism_cnt++;
    $display("Mismatch %s: held beat expected 1_%h, actual %b_%h", test_name,
             $sampled(beat_q), $sampled(replay_vld_o), $sampled(replay_beat_o));
  end

  a_no_acked: assert property (@(posedge clk_i) disable iff (rst_i)
    replay_vld_o |-> !acked[rs])
  else begin
    mism_cnt++;
    $display("Mismatch %s: acked seq %h expected 0 beats, actual 1", test_name,
             $sampled(replay_beat_o.seq));
  end

  a_ack_avail: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_pipe[1] |-> retry_available_o)
  else begin
    mism_cnt++;
    $display("Mismatch %s: available after ack expected 1, actual %b", test_name,
             $sampled(retry_available_o));
  end

  a_full: assert property (@(posedge clk_i) disable iff (rst_i)
    out_cnt == RETRY_SLOTS |-> !retry_available_o)
  else begin
    mism_cnt++;
    $display("Mismatch %s: available when full expected 0, actual %b", test_name,
             $sampled(retry_available_o));
  end

  a_nak: assert property (@(posedge clk_i) disable iff (rst_i)
    nak_wait |-> nak_cnt < REPLAY_TIMEOUT)
  else begin
    mism_cnt++;
    $display("Mismatch %s: nak replay delay expected < %0d, actual %0d", test_name,
             REPLAY_TIMEOUT, $sampled(nak_cnt));
  end

  a_replay_cap: assert property (@(posedge clk_i) disable iff (rst_i)
    err_test && replay_vld_o && rp_idx == 0 |-> replay_cnt[rs] < MAX_REPLAYS)
  else begin
    mism_cnt++;
    $display("Mismatch %s: replays expected %0d, actual %0d", test_name,
             MAX_REPLAYS, $sampled(replay_cnt[rs]) + 1);
  end

  a_err_count: assert property (@(posedge clk_i) disable iff (rst_i)
    err_test && retry_err_o |-> replay_cnt[0] == MAX_REPLAYS)
  else begin
    mism_cnt++;
    $display("Mismatch %s: replays before error expected %0d, actual %0d", test_name,
             MAX_REPLAYS, $sampled(replay_cnt[0]));
  end

  a_err_sticky: assert property (@(posedge clk_i) disable iff (rst_i)
    err_q |-> retry_err_o)
  else begin
    mism_cnt++;
    $display("Mismatch %s: retry_err_o expected 1, actual 0", test_name);
  end

  task automatic apply_reset(input string name, input logic rnd, input logic err);
    @(negedge clk_i);
    test_name     = name;
    rst_i         = 1'b1;
    tx_beat_vld_i = 1'b0;
    ack_vld_i     = 1'b0;
    next_seq      = 0;
    rdy_random    = rnd;
    err_test      = err;
    repeat (5) @(negedge clk_i);
    rst_i = 1'b0;
  endtask

  // one TLP of random length, the cycle after the last word stays idle
  task automatic send_tlp();
    int len;
    int s;
    int waited;
    waited = 0;
    while (!retry_available_o && waited < 400) begin
      @(negedge clk_i);
      waited++;
    end
    len         = rand_range(1, 15);
    s           = next_seq % 64;
    tlp_len[s]  = len;
    for (int i = 0; i < len; i++) begin
      tlp_data[s][i] = {16'(rand_range(0, 65535)), 16'(rand_range(0, 65535))};
      tx_beat_i.data = tlp_data[s][i];
      tx_beat_i.last = (i == len - 1);
      tx_beat_vld_i  = 1'b1;
      @(negedge clk_i);
      tx_beat_vld_i = 1'b0;
      if (i < len - 1) begin
        repeat (rand_range(0, 2)) @(negedge clk_i);
      end
    end
    if (!tlp_sent_o) begin
      fail_cnt++;
      $display("%s: no tlp_sent_o pulse after TLP %0d", test_name, next_seq);
    end
    @(negedge clk_i);
    next_seq++;
  endtask

  task automatic send_ack(input int seq, input logic is_ack);
    ack_i.is_ack = is_ack;
    ack_i.seq    = seq_num_t'(seq);
    ack_vld_i    = 1'b1;
    @(negedge clk_i);
    ack_vld_i = 1'b0;
  endtask

  // waits until every TLP sent so far has been replayed at least once
  task automatic wait_replays(input int limit);
    int  cyc;
    logic seen;
    cyc  = 0;
    seen = 1'b0;
    while (!seen && cyc < limit) begin
      @(negedge clk_i);
      cyc++;
      seen = 1'b1;
      for (int i = 0; i < next_seq; i++) begin
        if (replay_cnt[i] == 0) begin
          seen = 1'b0;
        end
      end
    end
    if (!seen) begin
      fail_cnt++;
      $display("%s: not every TLP was replayed within %0d cycles", test_name, limit);
    end
  endtask

  initial begin
    int cyc;
    rst_i         = 1'b1;
    tx_beat_i     = '0;
    tx_beat_vld_i = 1'b0;
    ack_i         = '0;
    ack_vld_i     = 1'b0;
    rdy_random    = 1'b0;
    err_test      = 1'b0;
    next_seq      = 0;

    apply_reset("numbering", 1'b0, 1'b0);
    repeat (6) begin
      send_tlp();
      send_ack(next_seq - 1, 1'b1);
    end

    apply_reset("replay", 1'b1, 1'b0);
    send_tlp();
    send_tlp();
    wait_replays(400);

    apply_reset("ack", 1'b0, 1'b0);
    repeat (3) begin
      send_tlp();
      send_ack(next_seq - 1, 1'b1);
    end
    send_tlp();
    repeat (3 * REPLAY_TIMEOUT) @(negedge clk_i);

    apply_reset("nak", 1'b1, 1'b0);
    send_tlp();
    send_ack(0, 1'b0);
    cyc = 0;
    while (replay_cnt[0] == 0 && cyc < 2 * REPLAY_TIMEOUT) begin
      @(negedge clk_i);
      cyc++;
    end
    if (replay_cnt[0] == 0) begin
      fail_cnt++;
      $display("nak: the NAKed TLP was never replayed");
    end

    apply_reset("full", 1'b1, 1'b0);
    repeat (RETRY_SLOTS) send_tlp();
    send_ack(RETRY_SLOTS - 1, 1'b1);
    repeat (100) @(negedge clk_i);

    apply_reset("error", 1'b1, 1'b1);
    send_tlp();
    cyc = 0;
    while (!retry_err_o && cyc < 700) begin
      @(negedge clk_i);
      cyc++;
    end
    if (!retry_err_o) begin
      fail_cnt++;
      $display("error: retry_err_o never rose for the unACKed TLP");
    end
    repeat (100) @(negedge clk_i);

    $display("Errors: %0d assertion mismatches, %0d other failures", mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== src/dll_tx_top.sv ====
`timescale 1ns/1ps

module dll_tx_top #(
  parameter int RETRY_SLOTS    = 4,
  parameter int SLOT_WORDS     = 16,
  parameter int REPLAY_TIMEOUT = 160,
  parameter int MAX_REPLAYS    = 3
) (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  pcie_datalink_pkg::tlp_beat_t    tx_beat_i,
  input  logic                            tx_beat_vld_i,
  input  pcie_datalink_pkg::ack_dllp_t    ack_i,
  input  logic                            ack_vld_i,
  input  logic                            replay_rdy_i,
  output logic                            tlp_sent_o,
  output pcie_datalink_pkg::seq_num_t     tlp_seq_o,
  output logic                            retry_available_o,
  output logic                            retry_err_o,
  output pcie_datalink_pkg::replay_beat_t replay_beat_o,
  output logic                            replay_vld_o
);
  import replay_mem_pkg::*;

  ram_req_t     wr_req;
  logic         wr_vld;
  ram_req_t     rd_req;
  logic         rd_vld_req;
  logic         rd_gnt;
  replay_word_u rd_data;
  logic         rd_vld;
  logic [7:0]   slot_idx;

  tlp_capture #(
    .SLOT_WORDS(SLOT_WORDS)
  ) tlp_capture_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .beat_i    (tx_beat_i),
    .beat_vld_i(tx_beat_vld_i),
    .slot_idx_i(slot_idx),
    .wr_req_o  (wr_req),
    .wr_vld_o  (wr_vld),
    .sent_o    (tlp_sent_o),
    .sent_seq_o(tlp_seq_o)
  );

  retry_management #(
    .RETRY_SLOTS   (RETRY_SLOTS),
    .SLOT_WORDS    (SLOT_WORDS),
    .REPLAY_TIMEOUT(REPLAY_TIMEOUT),
    .MAX_REPLAYS   (MAX_REPLAYS)
  ) retry_management_inst (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .sent_i           (tlp_sent_o),
    .sent_seq_i       (tlp_seq_o),
    .ack_i            (ack_i),
    .ack_vld_i        (ack_vld_i),
    .rd_gnt_i         (rd_gnt),
    .rd_data_i        (rd_data),
    .rd_vld_i         (rd_vld),
    .replay_rdy_i     (replay_rdy_i),
    .slot_idx_o       (slot_idx),
    .retry_available_o(retry_available_o),
    .retry_err_o      (retry_err_o),
    .rd_req_o         (rd_req),
    .rd_vld_req_o     (rd_vld_req),
    .replay_beat_o    (replay_beat_o),
    .replay_vld_o     (replay_vld_o)
  );

  replay_buffer #(
    .RETRY_SLOTS(RETRY_SLOTS),
    .SLOT_WORDS (SLOT_WORDS)
  ) replay_buffer_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wr_req_i    (wr_req),
    .wr_vld_i    (wr_vld),
    .rd_req_i    (rd_req),
    .rd_vld_req_i(rd_vld_req),
    .rd_gnt_o    (rd_gnt),
    .rd_data_o   (rd_data),
    .rd_vld_o    (rd_vld)
  );

endmodule

// ==== src/retry_management.sv ====
`timescale 1ns/1ps

module retry_management #(
  parameter int RETRY_SLOTS    = 4,
  parameter int SLOT_WORDS     = 16,
  parameter int REPLAY_TIMEOUT = 160,
  parameter int MAX_REPLAYS    = 3
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           sent_i,
  input  pcie_datalink_pkg::seq_num_t    sent_seq_i,
  input  pcie_datalink_pkg::ack_dllp_t   ack_i,
  input  logic                           ack_vld_i,
  input  logic                           rd_gnt_i,
  input  replay_mem_pkg::replay_word_u   rd_data_i,
  input  logic                           rd_vld_i,
  input  logic                           replay_rdy_i,
  output logic [7:0]                     slot_idx_o,
  output logic                           retry_available_o,
  output logic                           retry_err_o,
  output replay_mem_pkg::ram_req_t       rd_req_o,
  output logic                           rd_vld_req_o,
  output pcie_datalink_pkg::replay_beat_t replay_beat_o,
  output logic                           replay_vld_o
);
  import pcie_datalink_pkg::*;

  localparam int TIMER_W = $clog2(REPLAY_TIMEOUT + 1);
  localparam int CNT_W   = $clog2(MAX_REPLAYS + 1);

  typedef enum logic [2:0] {ST_IDLE, ST_COUNT, ST_PEND, ST_REPLAY, ST_ERR} slot_st_e;
  typedef enum logic [1:0] {RP_IDLE, RP_HDR_RD, RP_HDR_WAIT, RP_STREAM} eng_st_e;

  logic [RETRY_SLOTS-1:0] busy;
  logic [RETRY_SLOTS-1:0] pend;
  logic [RETRY_SLOTS-1:0] slot_err;
  logic [7:0]             slot_idx_r;
  logic [7:0]             free_idx;
  logic                   cur_busy;
  logic [7:0]             pick_idx;
  logic                   err_r;

  eng_st_e      eng_st;
  logic         eng_start;
  logic         done;
  logic [7:0]   act_slot_r;
  logic [7:0]   base_r;
  logic [7:0]   rd_off_r;
  logic [15:0]  req_left_r;
  logic [15:0]  rcv_cnt_r;
  logic [15:0]  word_cnt_r;
  seq_num_t     hdr_seq_r;
  logic         out_free;
  logic         in_vld;
  replay_beat_t in_beat;
  replay_beat_t pf_r;
  logic         pf_vld_r;

  for (genvar i = 0; i < RETRY_SLOTS; i++) begin : gen_slot
    slot_st_e           st_r;
    logic [TIMER_W-1:0] timer_r;
    logic [CNT_W-1:0]   replays_r;
    seq_num_t           seq_r;
    logic               match;
    logic               hit_ack_r;
    logic               hit_nak_r;
    logic               fill;

    assign fill        = sent_i && (slot_idx_r == 8'(i));
    assign match       = ack_vld_i && busy[i] && (seq_r == ack_i.seq);
    assign busy[i]     = (st_r != ST_IDLE);
    assign pend[i]     = (st_r == ST_PEND);
    assign slot_err[i] = (st_r == ST_ERR);

    always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
        st_r      <= ST_IDLE;
        timer_r   <= '0;
        replays_r <= '0;
        hit_ack_r <= 1'b0;
        hit_nak_r <= 1'b0;
      end else begin
        hit_ack_r <= match && ack_i.is_ack;
        hit_nak_r <= match && !ack_i.is_ack;
        case (st_r)
          ST_IDLE: begin
            if (fill) begin
              st_r      <= ST_COUNT;
              timer_r   <= '0;
              replays_r <= '0;
            end
          end
          ST_COUNT: begin
            timer_r <= timer_r + TIMER_W'(1);
            if (hit_nak_r) begin
              st_r <= ST_PEND;
            end else if (timer_r == TIMER_W'(REPLAY_TIMEOUT - 1)) begin
              // only timeouts count towards the error
              if (replays_r == CNT_W'(MAX_REPLAYS)) begin
                st_r <= ST_ERR;
              end else begin
                st_r      <= ST_PEND;
                replays_r <= replays_r + CNT_W'(1);
              end
            end
          end
          ST_PEND: begin
            if (eng_start && pick_idx == 8'(i)) begin
              st_r <= ST_REPLAY;
            end
          end
          ST_REPLAY: begin
            if (done && act_slot_r == 8'(i)) begin
              st_r    <= ST_COUNT;
              timer_r <= '0;
            end
          end
          default: begin
          end
        endcase
        if (hit_ack_r) begin
          st_r <= ST_IDLE;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (fill) begin
        seq_r <= sent_seq_i;
      end
    end
  end : gen_slot

  // lowest free slot, ignoring the one being filled now
  always_comb begin
    free_idx = slot_idx_r;
    cur_busy = 1'b0;
    pick_idx = '0;
    for (int i = RETRY_SLOTS - 1; i >= 0; i--) begin
      if (!busy[i] && !(sent_i && slot_idx_r == 8'(i))) begin
        free_idx = 8'(i);
      end
      if (slot_idx_r == 8'(i)) begin
        cur_busy = busy[i];
      end
      if (pend[i]) begin
        pick_idx = 8'(i);
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      slot_idx_r <= '0;
      err_r      <= 1'b0;
    end else begin
      if (sent_i || cur_busy) begin
        slot_idx_r <= free_idx;
      end
      if (|slot_err) begin
        err_r <= 1'b1;
      end
    end
  end

  assign slot_idx_o        = slot_idx_r;
  assign retry_available_o = !(&busy);
  assign retry_err_o       = err_r;

  // replay engine
  assign eng_start = (eng_st == RP_IDLE) && (|pend);
  assign out_free  = !replay_vld_o || replay_rdy_i;
  assign in_vld    = rd_vld_i && (eng_st == RP_STREAM);
  assign done      = replay_vld_o && replay_rdy_i && replay_beat_o.last;

  // one read in flight at most, and only while its word has a place to land
  assign rd_vld_req_o = (eng_st == RP_HDR_RD) ||
                        ((eng_st == RP_STREAM) && (req_left_r != '0) &&
                         !pf_vld_r && !(in_vld && !out_free));

  always_comb begin
    rd_req_o      = '0;
    rd_req_o.addr = base_r + rd_off_r;
    in_beat.data  = rd_data_i.data;
    in_beat.last  = (rcv_cnt_r == word_cnt_r - 16'd1);
    in_beat.seq   = hdr_seq_r;
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      eng_st     <= RP_IDLE;
      act_slot_r <= '0;
      base_r     <= '0;
      rd_off_r   <= '0;
      req_left_r <= '0;
      rcv_cnt_r  <= '0;
      word_cnt_r <= '0;
    end else begin
      case (eng_st)
        RP_IDLE: begin
          if (eng_start) begin
            act_slot_r <= pick_idx;
            base_r     <= 8'(pick_idx * SLOT_WORDS);
            rd_off_r   <= '0;
            eng_st     <= RP_HDR_RD;
          end
        end
        RP_HDR_RD: begin
          if (rd_gnt_i) begin
            rd_off_r <= 8'd1;
            eng_st   <= RP_HDR_WAIT;
          end
        end
        RP_HDR_WAIT: begin
          if (rd_vld_i) begin
            word_cnt_r <= rd_data_i.hdr.word_count;
            req_left_r <= rd_data_i.hdr.word_count;
            rcv_cnt_r  <= '0;
            eng_st     <= RP_STREAM;
          end
        end
        default: begin
          if (rd_gnt_i) begin
            rd_off_r   <= rd_off_r + 8'd1;
            req_left_r <= req_left_r - 16'd1;
          end
          if (in_vld) begin
            rcv_cnt_r <= rcv_cnt_r + 16'd1;
          end
          if (done) begin
            eng_st <= RP_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (eng_st == RP_HDR_WAIT && rd_vld_i) begin
      hdr_seq_r <= rd_data_i.hdr.seq;
    end
  end

  // output register plus one prefetched word, pf is always the older one
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      replay_vld_o <= 1'b0;
      pf_vld_r     <= 1'b0;
    end else begin
      if (out_free) begin
        replay_vld_o <= pf_vld_r || in_vld;
      end
      if (in_vld && (pf_vld_r == out_free)) begin
        pf_vld_r <= 1'b1;
      end else if (out_free) begin
        pf_vld_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_free && (pf_vld_r || in_vld)) begin
      replay_beat_o <= pf_vld_r ? pf_r : in_beat;
    end
    if (in_vld && (pf_vld_r == out_free)) begin
      pf_r <= in_beat;
    end
  end

endmodule

// ==== src/replay_buffer.sv ====
`timescale 1ns/1ps

module replay_buffer #(
  parameter int RETRY_SLOTS = 4,
  parameter int SLOT_WORDS  = 16
) (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  replay_mem_pkg::ram_req_t     wr_req_i,
  input  logic                         wr_vld_i,
  input  replay_mem_pkg::ram_req_t     rd_req_i,
  input  logic                         rd_vld_req_i,
  output logic                         rd_gnt_o,
  output replay_mem_pkg::replay_word_u rd_data_o,
  output logic                         rd_vld_o
);
  import replay_mem_pkg::*;

  localparam int DEPTH = RETRY_SLOTS * SLOT_WORDS;
  localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  replay_word_u  mem [DEPTH];
  ram_req_t      port_req;
  logic          port_en;
  logic [AW-1:0] port_addr;

  // capture writes always win the port
  assign rd_gnt_o  = rd_vld_req_i && !wr_vld_i;
  assign port_req  = wr_vld_i ? wr_req_i : rd_req_i;
  assign port_en   = wr_vld_i || rd_vld_req_i;
  assign port_addr = port_req.addr[AW-1:0];

  always_ff @(posedge clk_i) begin
    if (port_en) begin
      if (port_req.we) begin
        mem[port_addr] <= port_req.wdata;
      end else begin
        rd_data_o <= mem[port_addr];
      end
    end
  end

  // data of a granted read shows up one cycle later
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      rd_vld_o <= 1'b0;
    end else begin
      rd_vld_o <= port_en && !port_req.we;
    end
  end

endmodule

// ==== src/tlp_capture.sv ====
`timescale 1ns/1ps

module tlp_capture #(
  parameter int SLOT_WORDS = 16
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  pcie_datalink_pkg::tlp_beat_t beat_i,
  input  logic                        beat_vld_i,
  input  logic [7:0]                  slot_idx_i,
  output replay_mem_pkg::ram_req_t    wr_req_o,
  output logic                        wr_vld_o,
  output logic                        sent_o,
  output pcie_datalink_pkg::seq_num_t sent_seq_o
);
  import pcie_datalink_pkg::*;
  import replay_mem_pkg::*;

  logic         in_tlp_r;
  logic         hdr_pend_r;
  logic [7:0]   base_r;
  logic [7:0]   base_c;
  logic [15:0]  count_r;
  logic [15:0]  count_c;
  seq_num_t     seq_r;
  replay_word_u hdr_word;

  // slot base taken from the retry manager on the first word only
  assign base_c  = in_tlp_r ? base_r : 8'(slot_idx_i * SLOT_WORDS);
  assign count_c = in_tlp_r ? count_r : '0;

  always_comb begin
    hdr_word                = '0;
    hdr_word.hdr.seq        = seq_r;
    hdr_word.hdr.word_count = count_r;
  end

  // header write owns the cycle after the last word,
  // so the sender leaves that cycle idle
  always_comb begin
    wr_req_o    = '0;
    wr_req_o.we = 1'b1;
    if (hdr_pend_r) begin
      wr_req_o.addr  = base_r;
      wr_req_o.wdata = hdr_word;
    end else begin
      wr_req_o.addr       = base_c + count_c[7:0] + 8'd1;
      wr_req_o.wdata.data = beat_i.data;
    end
  end

  assign wr_vld_o   = hdr_pend_r || beat_vld_i;
  assign sent_o     = hdr_pend_r;
  assign sent_seq_o = seq_r;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      in_tlp_r   <= 1'b0;
      hdr_pend_r <= 1'b0;
      count_r    <= '0;
      seq_r      <= '0;
    end else begin
      hdr_pend_r <= beat_vld_i && beat_i.last;
      if (beat_vld_i) begin
        in_tlp_r <= !beat_i.last;
        count_r  <= count_c + 16'd1;
      end
      // next TLP number, wraps at 4096
      if (hdr_pend_r) begin
        seq_r <= seq_r + seq_num_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_vld_i) begin
      base_r <= base_c;
    end
  end

endmodule

// ==== src/replay_mem_pkg.sv ====
package replay_mem_pkg;

  // replay RAM address width
  localparam int RAM_AW = 8;

  // word 0 of a replay slot
  typedef struct packed {
    logic [3:0]                  spare;
    pcie_datalink_pkg::seq_num_t seq;
    // number of data words that follow
    logic [15:0]                 word_count;
  } slot_hdr_t;

  // header word or raw data word
  typedef union packed {
    slot_hdr_t   hdr;
    logic [31:0] data;
  } replay_word_u;

  // single port request, read when we is low
  typedef struct packed {
    logic              we;
    logic [RAM_AW-1:0] addr;
    replay_word_u      wdata;
  } ram_req_t;

endpackage

// ==== src/pcie_datalink_pkg.sv ====
package pcie_datalink_pkg;

  // sequence number width of the data link layer
  localparam int SEQ_W = 12;

  typedef logic [SEQ_W-1:0] seq_num_t;

  // one word of an outgoing TLP
  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } tlp_beat_t;

  // received ACK/NAK
  typedef struct packed {
    // 1 for ACK, 0 for NAK
    logic     is_ack;
    seq_num_t seq;
  } ack_dllp_t;

  // replayed word, tagged with the TLP's sequence number
  typedef struct packed {
    logic [31:0] data;
    logic        last;
    seq_num_t    seq;
  } replay_beat_t;

endpackage
